// ==== src/cordic_defines.svh ====
// CORDIC unit parameters
`ifndef CORDIC_DEFINES_SVH
`define CORDIC_DEFINES_SVH

// Width of input coordinates, angles and results
`define CORDIC_DATA_WIDTH 16
// Internal coordinate width with headroom for the CORDIC gain
`define CORDIC_XY_WIDTH 18
// Number of micro-rotation stages
`define CORDIC_STAGES 14
`define CORDIC_OP_WIDTH 4

// Operation codes
`define CORDIC_OP_SIN 4'd1
`define CORDIC_OP_COS 4'd2
`define CORDIC_OP_SINCOS 4'd3
`define CORDIC_OP_ATAN 4'd5

// Inverse CORDIC gain 0.607253 in Q2.14
`define CORDIC_GAIN_INV 9949
// Binary angle of pi
`define CORDIC_HALF_TURN 32768

`endif

// ==== src/cordic_pkg.sv ====
// CORDIC shared types
`include "cordic_defines.svh"

package cordic_pkg;

    // ==============================
    // Operand word
    // ==============================

    // One 32-bit operand word, read as an angle or as a vector
    typedef union packed {
        // Rotation view for sin, cos and sincos
        struct packed {
            logic [`CORDIC_DATA_WIDTH-1:0] reserved;
            logic [`CORDIC_DATA_WIDTH-1:0] angle;
        } rot;
        // Vectoring view for atan
        struct packed {
            logic signed [`CORDIC_DATA_WIDTH-1:0] y;
            logic signed [`CORDIC_DATA_WIDTH-1:0] x;
        } vec;
    } operand_u;

    // ==============================
    // Arctangent table
    // ==============================

    // atan(2^-i) in binary-angle units, 65536 per full turn
    // Rounded to nearest
    localparam logic [`CORDIC_DATA_WIDTH-1:0] atan_table [`CORDIC_STAGES] = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297,
        16'd651,  16'd326,  16'd163,  16'd81,
        16'd41,   16'd20,   16'd10,   16'd5,
        16'd3,    16'd1
    };

endpackage

// ==== src/cordic_prerotate.sv ====
// CORDIC entry stage
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_prerotate (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 advance,
    input  logic                                 in_valid,
    input  logic [`CORDIC_OP_WIDTH-1:0]          op,
    input  cordic_pkg::operand_u                 operand,
    output logic                                 valid,
    output logic [`CORDIC_OP_WIDTH-1:0]          op_q,
    output logic                                 vectoring,
    output logic                                 err,
    output logic signed [`CORDIC_XY_WIDTH-1:0]   x,
    output logic signed [`CORDIC_XY_WIDTH-1:0]   y,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] z
);

    localparam int DW  = `CORDIC_DATA_WIDTH;
    localparam int XYW = `CORDIC_XY_WIDTH;
    localparam logic signed [XYW-1:0] GAIN_INV  = `CORDIC_GAIN_INV;
    localparam logic [DW-1:0]         HALF_TURN = `CORDIC_HALF_TURN;

    logic [DW-1:0]         angle;
    logic signed [XYW-1:0] vec_x;
    logic signed [XYW-1:0] vec_y;
    logic                  next_vectoring;
    logic                  next_err;
    logic signed [XYW-1:0] next_x;
    logic signed [XYW-1:0] next_y;
    logic signed [DW-1:0]  next_z;

    // ==============================
    // Operand decode
    // ==============================

    assign angle = operand.rot.angle;
    // Vector inputs sign extended into the wider datapath
    assign vec_x = {{(XYW-DW){operand.vec.x[DW-1]}}, operand.vec.x};
    assign vec_y = {{(XYW-DW){operand.vec.y[DW-1]}}, operand.vec.y};

    // Fold into the convergence range of about +-99 degrees
    always_comb begin
        next_vectoring = 1'b0;
        next_err       = 1'b0;
        next_x         = '0;
        next_y         = '0;
        next_z         = '0;
        case (op)
            `CORDIC_OP_SIN, `CORDIC_OP_COS, `CORDIC_OP_SINCOS: begin
                // Start on the x axis, prescaled by the inverse gain
                next_x = GAIN_INV;
                next_z = angle;
                // Top two bits differ when |angle| is above pi/2
                if (angle[DW-1] != angle[DW-2]) begin
                    next_x = -GAIN_INV;
                    next_z = angle + HALF_TURN;
                end
            end
            `CORDIC_OP_ATAN: begin
                next_vectoring = 1'b1;
                next_x         = vec_x;
                next_y         = vec_y;
                // Left half plane is mirrored through the origin
                if (vec_x[XYW-1]) begin
                    next_x = -vec_x;
                    next_y = -vec_y;
                    next_z = HALF_TURN;
                end
            end
            default: begin
                // Unknown code flows down with zero payload
                next_err = 1'b1;
            end
        endcase
    end

    // ==============================
    // Stage register
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (advance) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op_q      <= op;
            vectoring <= next_vectoring;
            err       <= next_err;
            x         <= next_x;
            y         <= next_y;
            z         <= next_z;
        end
    end

endmodule

// ==== src/cordic_microrotation.sv ====
// CORDIC micro-rotation stage
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_microrotation #(
    parameter int STAGE_INDEX = 0
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 advance,
    input  logic                                 in_valid,
    input  logic [`CORDIC_OP_WIDTH-1:0]          in_op,
    input  logic                                 in_vectoring,
    input  logic                                 in_err,
    input  logic signed [`CORDIC_XY_WIDTH-1:0]   in_x,
    input  logic signed [`CORDIC_XY_WIDTH-1:0]   in_y,
    input  logic signed [`CORDIC_DATA_WIDTH-1:0] in_z,
    output logic                                 valid,
    output logic [`CORDIC_OP_WIDTH-1:0]          op,
    output logic                                 vectoring,
    output logic                                 err,
    output logic signed [`CORDIC_XY_WIDTH-1:0]   x,
    output logic signed [`CORDIC_XY_WIDTH-1:0]   y,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] z
);

    localparam int DW  = `CORDIC_DATA_WIDTH;
    localparam int XYW = `CORDIC_XY_WIDTH;

    logic signed [XYW-1:0] x_shift;
    logic signed [XYW-1:0] y_shift;
    logic signed [DW-1:0]  atan_step;
    logic                  dir_pos;

    // ==============================
    // Rotation step
    // ==============================

    // Arithmetic shift keeps the sign of the coordinate
    assign x_shift   = in_x >>> STAGE_INDEX;
    assign y_shift   = in_y >>> STAGE_INDEX;
    assign atan_step = cordic_pkg::atan_table[STAGE_INDEX];

    // Rotation drives z to zero, vectoring drives y to zero
    assign dir_pos = in_vectoring ? in_y[XYW-1] : ~in_z[DW-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (advance) begin
            valid <= in_valid;
        end
    end

    // Payload moves with the valid bit, bubbles included
    always_ff @(posedge clk) begin
        if (advance) begin
            op        <= in_op;
            vectoring <= in_vectoring;
            err       <= in_err;
            if (dir_pos) begin
                // Counterclockwise step
                x <= in_x - y_shift;
                y <= in_y + x_shift;
                z <= in_z - atan_step;
            end else begin
                // Clockwise step
                x <= in_x + y_shift;
                y <= in_y - x_shift;
                z <= in_z + atan_step;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Valid bit stays known for the whole run once out of reset
    valid_known_a: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(valid)
    ) else $error("stage %0d valid unknown", STAGE_INDEX);

endmodule

// ==== src/cordic_result_select.sv ====
// CORDIC result stage
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_result_select (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 advance,
    input  logic                                 in_valid,
    input  logic [`CORDIC_OP_WIDTH-1:0]          in_op,
    input  logic                                 in_err,
    input  logic signed [`CORDIC_XY_WIDTH-1:0]   in_x,
    input  logic signed [`CORDIC_XY_WIDTH-1:0]   in_y,
    input  logic signed [`CORDIC_DATA_WIDTH-1:0] in_z,
    input  logic                                 out_ready,
    output logic                                 out_valid,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] result_primary,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] result_secondary,
    output logic                                 has_secondary,
    output logic                                 error
);

    localparam int DW  = `CORDIC_DATA_WIDTH;
    localparam int XYW = `CORDIC_XY_WIDTH;
    localparam int EXT = XYW - DW;

    logic signed [DW-1:0] x_narrow;
    logic signed [DW-1:0] y_narrow;
    logic signed [DW-1:0] sel_primary;
    logic signed [DW-1:0] sel_secondary;
    logic                 sel_has_secondary;
    logic                 sel_error;
    logic                 rotation_result;

    // Drop the gain headroom bits
    assign x_narrow = in_x[DW-1:0];
    assign y_narrow = in_y[DW-1:0];

    // ==============================
    // Result mux
    // ==============================

    always_comb begin
        sel_primary       = '0;
        sel_secondary     = '0;
        sel_has_secondary = 1'b0;
        sel_error         = 1'b0;
        if (in_err) begin
            sel_error = 1'b1;
        end else begin
            case (in_op)
                `CORDIC_OP_SIN:    sel_primary = y_narrow;
                `CORDIC_OP_COS:    sel_primary = x_narrow;
                `CORDIC_OP_SINCOS: begin
                    sel_primary       = y_narrow;
                    sel_secondary     = x_narrow;
                    sel_has_secondary = 1'b1;
                end
                // Accumulated angle is the arctangent
                `CORDIC_OP_ATAN:   sel_primary = in_z;
                default:           sel_error   = 1'b1;
            endcase
        end
    end

    // Exit register, held while the sink stalls
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            result_primary   <= sel_primary;
            result_secondary <= sel_secondary;
            has_secondary    <= sel_has_secondary;
            error            <= sel_error;
        end
    end

    // ==============================
    // Checks
    // ==============================

    assign rotation_result = in_valid && !in_err && (in_op != `CORDIC_OP_ATAN);

    // Prescaled start x keeps sin and cos inside 16 bits
    range_a: assert property (
        @(posedge clk) disable iff (reset)
        advance && rotation_result |->
            (in_x[XYW-1:DW] == {EXT{in_x[DW-1]}}) && (in_y[XYW-1:DW] == {EXT{in_y[DW-1]}})
    ) else $error("rotation result exceeds output width");

    // A stalled result holds until taken
    hold_a: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=>
            out_valid && $stable(result_primary) && $stable(result_secondary)
            && $stable(has_secondary) && $stable(error)
    ) else $error("result changed while stalled");

endmodule

// ==== src/cordic_trig_unit.sv ====
// CORDIC trigonometry unit
`timescale 1ns/10ps
`include "cordic_defines.svh"

module cordic_trig_unit (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  logic [`CORDIC_OP_WIDTH-1:0]          op,
    input  cordic_pkg::operand_u                 operand,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] result_primary,
    output logic signed [`CORDIC_DATA_WIDTH-1:0] result_secondary,
    output logic                                 has_secondary,
    output logic                                 error
);

    localparam int N   = `CORDIC_STAGES;
    localparam int DW  = `CORDIC_DATA_WIDTH;
    localparam int XYW = `CORDIC_XY_WIDTH;
    localparam int OPW = `CORDIC_OP_WIDTH;

    // Global stall, every stage register loads together
    logic advance;

    // Stage boundaries, index 0 is the prerotate output
    logic                  stage_valid     [0:N];
    logic [OPW-1:0]        stage_op        [0:N];
    logic                  stage_vectoring [0:N];
    logic                  stage_err       [0:N];
    logic signed [XYW-1:0] stage_x         [0:N];
    logic signed [XYW-1:0] stage_y         [0:N];
    logic signed [DW-1:0]  stage_z         [0:N];

    // ==============================
    // Flow control
    // ==============================

    // Pipeline moves when the exit slot is free or being emptied
    assign advance  = ~out_valid | out_ready;
    assign in_ready = advance;

    // ==============================
    // Datapath
    // ==============================

    cordic_prerotate u_prerotate (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .in_valid  (in_valid),
        .op        (op),
        .operand   (operand),
        .valid     (stage_valid[0]),
        .op_q      (stage_op[0]),
        .vectoring (stage_vectoring[0]),
        .err       (stage_err[0]),
        .x         (stage_x[0]),
        .y         (stage_y[0]),
        .z         (stage_z[0])
    );

    // One shift-and-add step per stage
    for (genvar i = 0; i < N; i++) begin : g_stage
        cordic_microrotation #(
            .STAGE_INDEX (i)
        ) u_micro (
            .clk          (clk),
            .reset        (reset),
            .advance      (advance),
            .in_valid     (stage_valid[i]),
            .in_op        (stage_op[i]),
            .in_vectoring (stage_vectoring[i]),
            .in_err       (stage_err[i]),
            .in_x         (stage_x[i]),
            .in_y         (stage_y[i]),
            .in_z         (stage_z[i]),
            .valid        (stage_valid[i+1]),
            .op           (stage_op[i+1]),
            .vectoring    (stage_vectoring[i+1]),
            .err          (stage_err[i+1]),
            .x            (stage_x[i+1]),
            .y            (stage_y[i+1]),
            .z            (stage_z[i+1])
        );
    end

    // Mode bit is not needed past the last rotation
    cordic_result_select u_result (
        .clk              (clk),
        .reset            (reset),
        .advance          (advance),
        .in_valid         (stage_valid[N]),
        .in_op            (stage_op[N]),
        .in_err           (stage_err[N]),
        .in_x             (stage_x[N]),
        .in_y             (stage_y[N]),
        .in_z             (stage_z[N]),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .result_primary   (result_primary),
        .result_secondary (result_secondary),
        .has_secondary    (has_secondary),
        .error            (error)
    );

endmodule

// ==== sim/tb_cordic_model.svh ====
// CORDIC reference model
`ifndef TB_CORDIC_MODEL_SVH
`define TB_CORDIC_MODEL_SVH

// Binary-angle units per radian, 65536 per full turn
localparam real BAU_PER_RAD = 32768.0 / 3.14159265358979;

// atan(2^-i) in binary-angle units, rounded to nearest
function automatic logic [15:0] atan_step(input int i);
    return 16'($rtoi($atan($pow(2.0, 0.0 - i)) * BAU_PER_RAD + 0.5));
endfunction

// Bit-exact expected outputs of one operation
function automatic void cordic_ref(
    input  logic [3:0]  c,
    input  logic [31:0] w,
    output logic [15:0] prim,
    output logic [15:0] sec,
    output logic        has_sec,
    output logic        err
);
    logic signed [17:0] x;
    logic signed [17:0] y;
    logic signed [17:0] xs;
    logic signed [17:0] ys;
    logic [15:0]        z;
    logic               vect;
    prim    = '0;
    sec     = '0;
    has_sec = 1'b0;
    err     = 1'b0;
    vect    = (c == `CORDIC_OP_ATAN);
    if (c == `CORDIC_OP_SIN || c == `CORDIC_OP_COS || c == `CORDIC_OP_SINCOS) begin
        // Unit vector prescaled by 1/K, folded when |angle| > pi/2
        x = 18'(`CORDIC_GAIN_INV);
        y = '0;
        z = w[15:0];
        if (z[15] != z[14]) begin
            x = -x;
            z = z + 16'(`CORDIC_HALF_TURN);
        end
    end else if (vect) begin
        x = {{2{w[15]}}, w[15:0]};
        y = {{2{w[31]}}, w[31:16]};
        z = '0;
        // Mirror the left half plane
        if (x < 0) begin
            x = -x;
            y = -y;
            z = 16'(`CORDIC_HALF_TURN);
        end
    end else begin
        err = 1'b1;
        return;
    end
    for (int i = 0; i < `CORDIC_STAGES; i++) begin
        xs = x >>> i;
        ys = y >>> i;
        if (vect ? (y < 0) : !z[15]) begin
            x = x - ys;
            y = y + xs;
            z = z - atan_step(i);
        end else begin
            x = x + ys;
            y = y - xs;
            z = z + atan_step(i);
        end
    end
    case (c)
        `CORDIC_OP_SIN: prim = y[15:0];
        `CORDIC_OP_COS: prim = x[15:0];
        `CORDIC_OP_SINCOS: begin
            prim    = y[15:0];
            sec     = x[15:0];
            has_sec = 1'b1;
        end
        default: prim = z;
    endcase
endfunction

// Ideal result in output LSB units, cosine when second is set
function automatic real ideal_value(input logic [3:0] c, input logic [31:0] w, input bit second);
    real a;
    a = $itor($signed(w[15:0])) / BAU_PER_RAD;
    if (c == `CORDIC_OP_ATAN) begin
        return $atan2($itor($signed(w[31:16])), $itor($signed(w[15:0]))) * BAU_PER_RAD;
    end
    if (c == `CORDIC_OP_COS || second) begin
        return $cos(a) * 16384.0;
    end
    return $sin(a) * 16384.0;
endfunction

`endif

// ==== sim/tb_cordic_trig_unit.sv ====
// CORDIC trigonometry unit testbench
`timescale 1ns/10ps
`include "cordic_defines.svh"

module tb_cordic_trig_unit;

    // Cycles from the accepting cycle to the first cycle with out_valid
    localparam int LATENCY    = 16;
    localparam int WAIT_LIMIT = 400;
    localparam real TOL       = 8.0;

    logic                                 clk;
    logic                                 reset;
    logic                                 in_valid;
    logic                                 in_ready;
    logic [`CORDIC_OP_WIDTH-1:0]          op;
    cordic_pkg::operand_u                 operand;
    logic                                 out_valid;
    logic                                 out_ready;
    logic signed [`CORDIC_DATA_WIDTH-1:0] result_primary;
    logic signed [`CORDIC_DATA_WIDTH-1:0] result_secondary;
    logic                                 has_secondary;
    logic                                 error;

    // Scoreboard, oldest accepted operation first
    logic [3:0]  exp_op    [$];
    logic [31:0] exp_word  [$];
    int          exp_cycle [$];

    int          errors;
    int          checked;
    int          cycle;
    bit          stall_mode;
    bit          check_latency;
    bit          held;
    logic [33:0] held_value;

    `include "tb_cordic_model.svh"

    cordic_trig_unit u_dut (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .op               (op),
        .operand          (operand),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .result_primary   (result_primary),
        .result_secondary (result_secondary),
        .has_secondary    (has_secondary),
        .error            (error)
    );

    always #5 clk = ~clk;

    // Cycle count and sink back-pressure
    always @(posedge clk) begin
        cycle = cycle + 1;
        #1;
        out_ready = stall_mode ? ($urandom_range(2, 0) != 0) : 1'b1;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Checked %0d results, %0d errors", checked, errors + 1);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic fail_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        errors++;
        $display("Fail %s: got %h expected %h", name, got, exp);
    endtask

    // Distance to the ideal value, angles wrap around the full turn
    task automatic check_near(input string name, input int got, input real want, input bit wrap);
        real d;
        d = $itor(got) - want;
        if (wrap && d > 32768.0) d = d - 65536.0;
        if (wrap && d < -32768.0) d = d + 65536.0;
        if (d > TOL || d < -TOL) begin
            errors++;
            $display("Fail %s: got %h ideal %h", name, 16'(got), 16'($rtoi(want)));
        end
    endtask

    task automatic compare_result(input logic [3:0] c, input logic [31:0] w, input int acc);
        logic [15:0] prim;
        logic [15:0] sec;
        logic        has_sec;
        logic        err;
        cordic_ref(c, w, prim, sec, has_sec, err);
        checked++;
        if (result_primary !== prim) fail_value("result_primary", result_primary, prim);
        if (result_secondary !== sec) fail_value("result_secondary", result_secondary, sec);
        if (has_secondary !== has_sec) fail_value("has_secondary", has_secondary, has_sec);
        if (error !== err) fail_value("error", error, err);
        if (!err) check_near("result_primary", result_primary, ideal_value(c, w, 0),
                             c == `CORDIC_OP_ATAN);
        if (has_sec) check_near("result_secondary", result_secondary, ideal_value(c, w, 1), 0);
        if (check_latency && cycle - acc != LATENCY) begin
            errors++;
            $display("Result of op %0d came %0d cycles after acceptance", c, cycle - acc);
        end
    endtask

    // Vector with both components away from zero, random quadrant
    function automatic logic [31:0] random_vector();
        int vx;
        int vy;
        vx = $urandom_range(32767, 1024);
        vy = $urandom_range(32767, 1024);
        if ($urandom_range(1, 0) != 0) vx = -vx;
        if ($urandom_range(1, 0) != 0) vy = -vy;
        return {16'(vy), 16'(vx)};
    endfunction

    // Present one operation and hold it until accepted
    task automatic send_op(input logic [3:0] c, input logic [31:0] w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        op       = c;
        operand  = w;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("in_ready stayed low too long");
            @(negedge clk);
        end
        if (check_latency && waited != 0) begin
            errors++;
            $display("in_ready was low while out_ready was held high");
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_op.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("accepted operations never came out");
            @(posedge clk);
        end
        #1;
    endtask

    // ==============================
    // Scoreboard and compare
    // ==============================

    always @(negedge clk) begin
        if (!reset) begin
            // Stalled outputs must hold
            if (held && !out_valid) begin
                errors++;
                $display("out_valid dropped while the result was stalled");
            end else if (held && {result_primary, result_secondary, has_secondary, error}
                         !== held_value) begin
                errors++;
                $display("Fail held outputs: got %h expected %h",
                         {result_primary, result_secondary, has_secondary, error}, held_value);
            end
            held       = out_valid && !out_ready;
            held_value = {result_primary, result_secondary, has_secondary, error};
            if (in_valid && in_ready) begin
                exp_op.push_back(op);
                exp_word.push_back(operand);
                exp_cycle.push_back(cycle);
            end
            if (out_valid && out_ready) begin
                if (exp_op.size() == 0) begin
                    errors++;
                    $display("Result taken with no operation outstanding");
                end else begin
                    compare_result(exp_op.pop_front(), exp_word.pop_front(),
                                   exp_cycle.pop_front());
                end
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        logic [3:0] c;
        void'($urandom(32'hb7ecd4e5));
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        op            = '0;
        operand       = '0;
        out_ready     = 1'b1;
        stall_mode    = 1'b0;
        check_latency = 1'b0;
        held          = 1'b0;
        held_value    = '0;
        errors        = 0;
        checked       = 0;
        cycle         = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle after reset
        @(negedge clk);
        if (out_valid !== 1'b0) fail_value("out_valid", out_valid, 16'h0);
        if (in_ready !== 1'b1) fail_value("in_ready", in_ready, 16'h1);
        @(posedge clk);
        #1;
        // sin, cos and sincos over random angles, reserved bits random too
        for (int k = 1; k <= 3; k++) begin
            for (int n = 0; n < 200; n++) send_op(4'(k), $urandom);
        end
        for (int n = 0; n < 200; n++) send_op(`CORDIC_OP_ATAN, random_vector());
        // Unknown codes interleaved with valid work
        for (int k = 0; k < 16; k++) begin
            if (!(k inside {1, 2, 3, 5})) begin
                send_op(4'(k), $urandom);
                send_op(`CORDIC_OP_SINCOS, $urandom);
            end
        end
        // Random back-pressure with a mix of all codes
        stall_mode = 1'b1;
        for (int n = 0; n < 150; n++) begin
            c = 4'($urandom_range(15, 0));
            send_op(c, (c == `CORDIC_OP_ATAN) ? random_vector() : $urandom);
        end
        stall_mode = 1'b0;
        drain();
        // Lone operation, then a back-to-back burst
        check_latency = 1'b1;
        send_op(`CORDIC_OP_COS, $urandom);
        drain();
        for (int n = 0; n < 8; n++) send_op(4'($urandom_range(3, 1)), $urandom);
        drain();
        check_latency = 1'b0;
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== cordic_trig_unit.f ====
+incdir+src
+incdir+sim
src/cordic_pkg.sv
src/cordic_prerotate.sv
src/cordic_microrotation.sv
src/cordic_result_select.sv
src/cordic_trig_unit.sv
sim/tb_cordic_trig_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CORDIC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cordic_trig_unit \
    -f cordic_trig_unit.f

# Simulation status is taken from the log
./obj_dir/Vtb_cordic_trig_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
